// File: Makefile
# Verilator flow for the OoO commit unit

TOP       ?= ooo_commit_unit_tb
FILELIST  ?= ooo_commit_unit.f
BUILD_DIR ?= build
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || { echo "Simulation ended early, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/completion_buffer_checker.sv
`timescale 1ns/100ps

// Retirement rules of the completion buffer, checked every cycle
// Bound into completion_buffer from the testbench

module completion_buffer_checker (
  input logic CLK,
  input logic nRST,
  input logic retire,
  input logic flush,
  input logic commit_valid,
  input logic exc_valid,
  input logic mispredict
);

  // A retiring entry is either a commit or an exception
  a_one_kind: assert property (@(posedge CLK) disable iff (~nRST)
    !(commit_valid && exc_valid))
    else $error("commit_valid and exc_valid high in the same cycle");

  a_flush_cause: assert property (@(posedge CLK) disable iff (~nRST)
    flush |-> (exc_valid || mispredict))  // Only wrong-path events flush
    else $error("flush without an exception or a mispredict");

  a_retire_out: assert property (@(posedge CLK) disable iff (~nRST)
    retire |-> (commit_valid || exc_valid))
    else $error("slot freed with no commit or exception output");

endmodule

// File: bench/ooo_commit_unit_tb.sv
`timescale 1ns/100ps

// Directed testbench for the OoO commit unit
// A model queue of dispatched entries predicts every retirement

module ooo_commit_unit_tb;

  typedef struct packed {
    commit_pkg::kind_t            kind;
    logic [31:0]                  pc;
    logic [4:0]                   rd;
    logic [commit_pkg::tag_w-1:0] tag;
    commit_pkg::fu_payload_u      pl;  // Result reported later
  } ent_t;

  typedef struct packed {
    logic               is_exc;
    logic               wen;
    logic [4:0]         rd;
    logic [31:0]        pc;
    logic [31:0]        wdata;
    commit_pkg::cause_t cause;
    logic [31:0]        epc;
    logic [31:0]        badaddr;
    logic               upd;
    logic [31:0]        upd_pc;
    logic [31:0]        target;
    logic               taken;
    logic               misp;
  } ret_t;

  logic                                                   CLK;
  logic                                                   nRST;
  logic                                                   disp_valid;
  commit_pkg::kind_t                                      disp_kind;
  logic [31:0]                                            disp_pc;
  logic [4:0]                                             disp_rd;
  logic                                                   disp_ready;
  logic [commit_pkg::tag_w-1:0]                           disp_tag;
  logic [commit_pkg::num_lanes-1:0]                       fu_valid;
  logic [commit_pkg::num_lanes-1:0][commit_pkg::tag_w-1:0] fu_tag;
  commit_pkg::fu_payload_u [commit_pkg::num_lanes-1:0]    fu_payload;
  logic                                                   commit_valid;
  logic                                                   commit_wen;
  logic [4:0]                                             commit_rd;
  logic [31:0]                                            commit_pc;
  logic [31:0]                                            commit_wdata;
  logic                                                   exc_valid;
  commit_pkg::cause_t                                     exc_cause;
  logic [31:0]                                            exc_epc;
  logic [31:0]                                            exc_badaddr;
  logic                                                   pred_update;
  logic [31:0]                                            pred_pc;
  logic [31:0]                                            pred_target;
  logic                                                   pred_taken;
  logic                                                   mispredict;

  ent_t                         model_q [$];  // Dispatched, not yet retired
  ret_t                         ret_q [$];    // Retirements seen on the outputs
  logic [commit_pkg::tag_w-1:0] next_tag = '0;
  logic [31:0]                  rng = 32'd11;

  ooo_commit_unit uut (.*);

  bind completion_buffer completion_buffer_checker u_checker (
    .CLK          (CLK),
    .nRST         (nRST),
    .retire       (retire),
    .flush        (flush),
    .commit_valid (commit_valid),
    .exc_valid    (exc_valid),
    .mispredict   (mispredict)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  task automatic abort(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped at first error");
  endtask

  // Retirement outputs are settled by the falling edge
  always @(negedge CLK) begin : sample_retire
    ret_t ev;
    if (nRST && (commit_valid || exc_valid)) begin
      if (commit_valid && exc_valid)
        abort("commit and exception retired in the same cycle");
      ev.is_exc  = exc_valid;
      ev.wen     = commit_wen;
      ev.rd      = commit_rd;
      ev.pc      = commit_pc;
      ev.wdata   = commit_wdata;
      ev.cause   = exc_cause;
      ev.epc     = exc_epc;
      ev.badaddr = exc_badaddr;
      ev.upd     = pred_update;
      ev.upd_pc  = pred_pc;
      ev.target  = pred_target;
      ev.taken   = pred_taken;
      ev.misp    = mispredict;
      ret_q.push_back(ev);
    end
  end

  task automatic step();
    @(posedge CLK);
    #2;  // Inputs change just after the edge
  endtask

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng = x;
    return x;
  endfunction

  function automatic commit_pkg::fu_payload_u data_pl(input logic [31:0] word);
    commit_pkg::fu_payload_u p;
    p.data.pad  = 2'b00;
    p.data.word = word;
    return p;
  endfunction

  function automatic commit_pkg::fu_payload_u ctrl_pl(input logic taken, input logic pred,
                                                      input logic [31:0] target);
    commit_pkg::fu_payload_u p;
    p.ctrl.taken     = taken;
    p.ctrl.predicted = pred;
    p.ctrl.target    = target;
    return p;
  endfunction

  function automatic logic is_ctrl(input commit_pkg::kind_t k);
    return k inside {commit_pkg::branch, commit_pkg::jump};
  endfunction

  // Expected cause from kind and the low two address bits
  function automatic commit_pkg::cause_t exp_cause(input ent_t e);
    case (e.kind)
      commit_pkg::load:   return (e.pl.data.word[1:0] != 2'b00) ? commit_pkg::mal_load
                                                                : commit_pkg::none;
      commit_pkg::store:  return (e.pl.data.word[1:0] != 2'b00) ? commit_pkg::mal_store
                                                                : commit_pkg::none;
      commit_pkg::branch,
      commit_pkg::jump:   return (e.pl.ctrl.target[1:0] != 2'b00) ? commit_pkg::mal_insn
                                                                  : commit_pkg::none;
      commit_pkg::ecall:  return commit_pkg::env_call;
      default:            return commit_pkg::none;
    endcase
  endfunction

  function automatic logic [31:0] exp_badaddr(input ent_t e);
    if (e.kind inside {commit_pkg::load, commit_pkg::store})
      return e.pl.data.word;
    if (is_ctrl(e.kind))
      return e.pl.ctrl.target;
    return 32'd0;  // Nothing to report for ecall
  endfunction

  function automatic logic [31:0] exp_wdata(input ent_t e);
    return (e.kind == commit_pkg::jump) ? e.pc + 32'd4 : e.pl.data.word;  // Link address
  endfunction

  function automatic logic exp_wen(input ent_t e);
    logic writes;
    writes = e.kind inside {commit_pkg::alu, commit_pkg::mul, commit_pkg::div,
                            commit_pkg::load, commit_pkg::jump};
    return writes && (e.rd != 5'd0);
  endfunction

  task automatic check_tag(input string name, input logic [commit_pkg::tag_w-1:0] exp,
                           input logic [commit_pkg::tag_w-1:0] act);
    if (act !== exp)
      abort($sformatf("CHECK FAILED %s: expected tag=%0d, actual tag=%0d", name, exp, act));
  endtask

  task automatic check_commit(input string name, input logic exp_wen_v,
                              input logic [4:0] exp_rd, input logic [31:0] exp_pc,
                              input logic [31:0] exp_wd, input ret_t ev);
    if (ev.is_exc)
      abort($sformatf("%s: an exception retired where a commit was expected", name));
    if (ev.wen !== exp_wen_v || ev.rd !== exp_rd || ev.pc !== exp_pc ||
        (exp_wen_v && ev.wdata !== exp_wd))
      abort($sformatf({"CHECK FAILED %s: expected wen=%0b rd=%0d pc=%h wdata=%h,",
                       " actual wen=%0b rd=%0d pc=%h wdata=%h"}, name, exp_wen_v, exp_rd,
                      exp_pc, exp_wd, ev.wen, ev.rd, ev.pc, ev.wdata));
  endtask

  task automatic check_exc(input string name, input commit_pkg::cause_t exp_c,
                           input logic [31:0] exp_epc, input logic [31:0] exp_bad,
                           input ret_t ev);
    commit_pkg::cause_t act_c;
    act_c = ev.cause;
    if (!ev.is_exc)
      abort($sformatf("%s: a commit retired where an exception was expected", name));
    if (act_c !== exp_c || ev.epc !== exp_epc || ev.badaddr !== exp_bad)
      abort($sformatf({"CHECK FAILED %s: expected cause=%s epc=%h badaddr=%h,",
                       " actual cause=%s epc=%h badaddr=%h"}, name, exp_c.name(), exp_epc,
                      exp_bad, act_c.name(), ev.epc, ev.badaddr));
  endtask

  task automatic check_pred(input string name, input logic exp_upd, input logic [31:0] exp_pc,
                            input logic [31:0] exp_tgt, input logic exp_tk,
                            input logic exp_misp, input ret_t ev);
    if (ev.upd !== exp_upd || ev.misp !== exp_misp ||
        (exp_upd && (ev.upd_pc !== exp_pc || ev.target !== exp_tgt || ev.taken !== exp_tk)))
      abort($sformatf({"CHECK FAILED %s: expected upd=%0b pc=%h target=%h taken=%0b",
                       " misp=%0b, actual upd=%0b pc=%h target=%h taken=%0b misp=%0b"},
                      name, exp_upd, exp_pc, exp_tgt, exp_tk, exp_misp, ev.upd,
                      ev.upd_pc, ev.target, ev.taken, ev.misp));
  endtask

  task automatic flush_model();
    model_q.delete();  // Younger entries are wrong path
    next_tag = '0;     // Tail restarts at slot 0
  endtask

  task automatic dispatch(input string name, input commit_pkg::kind_t kind,
                          input logic [31:0] pc, input logic [4:0] rd,
                          input commit_pkg::fu_payload_u pl);
    ent_t e;
    int   waited;
    waited = 0;
    while (!disp_ready) begin
      if (waited == 40)
        abort($sformatf("%s: timeout waiting for disp_ready", name));
      step();
      waited++;
    end
    disp_valid = 1'b1;
    disp_kind  = kind;
    disp_pc    = pc;
    disp_rd    = rd;
    check_tag(name, next_tag, disp_tag);  // Tag comes in the same cycle
    e.kind = kind;
    e.pc   = pc;
    e.rd   = rd;
    e.tag  = disp_tag;
    e.pl   = pl;
    model_q.push_back(e);
    next_tag = next_tag + 1'b1;
    step();
    disp_valid = 1'b0;
  endtask

  // One result on a random lane
  task automatic report(input logic [commit_pkg::tag_w-1:0] tag,
                        input commit_pkg::fu_payload_u pl);
    int lane;
    lane = int'(next_rand() % 32'd4);
    fu_valid[lane]   = 1'b1;
    fu_tag[lane]     = tag;
    fu_payload[lane] = pl;
    step();
    fu_valid = '0;
  endtask

  task automatic expect_retire(input string name);
    ent_t               e;
    ret_t               ev;
    commit_pkg::cause_t cause;
    logic               misp;
    int                 waited;
    waited = 0;
    while (ret_q.size() == 0) begin
      if (waited == 40)
        abort($sformatf("%s: timeout waiting for a retirement", name));
      step();
      waited++;
    end
    if (model_q.size() == 0)
      abort($sformatf("%s: retirement with no dispatched entry left", name));
    ev    = ret_q.pop_front();
    e     = model_q.pop_front();  // Oldest entry retires first
    cause = exp_cause(e);
    misp  = is_ctrl(e.kind) && (e.pl.ctrl.taken != e.pl.ctrl.predicted);
    if (cause != commit_pkg::none) begin
      check_exc(name, cause, e.pc, exp_badaddr(e), ev);
      flush_model();
    end else begin
      check_commit(name, exp_wen(e), e.rd, e.pc, exp_wdata(e), ev);
      check_pred(name, is_ctrl(e.kind), e.pc, e.pl.ctrl.target, e.pl.ctrl.taken, misp, ev);
      if (misp)
        flush_model();
    end
  endtask

  // Nothing may retire inside the window
  task automatic check_quiet(input string name, input int cycles);
    repeat (cycles) step();
    if (ret_q.size() != 0)
      abort($sformatf("%s: a flushed or undispatched entry retired", name));
  endtask

  task automatic test_reset_state();
    if (commit_valid || exc_valid || pred_update || mispredict || disp_ready)
      abort("reset_state: an output is high right after reset");
    step();
    if (!disp_ready)
      abort("reset_state: disp_ready did not rise after reset");
    report(3'd0, data_pl(32'h1234_5678));  // Head tag, never dispatched
    check_quiet("reset_state", 6);
  endtask

  task automatic test_in_order();
    commit_pkg::kind_t k;
    logic [31:0]       word;
    for (int i = 0; i < 8; i++) begin
      k    = (i % 3 == 0) ? commit_pkg::alu : (i % 3 == 1) ? commit_pkg::mul : commit_pkg::load;
      word = next_rand();
      if (k == commit_pkg::load)
        word[1:0] = 2'b00;  // Aligned load
      dispatch("in_order", k, 32'h0000_1000 + 32'(i) * 32'd4, (i == 3) ? 5'd0 : 5'(i + 1),
               data_pl(word));
    end
    for (int i = 7; i >= 0; i--)
      report(model_q[i].tag, model_q[i].pl);  // Youngest first
    repeat (8) expect_retire("in_order");
  endtask

  task automatic test_full_buffer();
    for (int i = 0; i < 8; i++)
      dispatch("full_buffer", commit_pkg::div, 32'h0000_2000 + 32'(i) * 32'd4, 5'(i + 8),
               data_pl(next_rand()));
    if (disp_ready)
      abort("full_buffer: disp_ready high with eight entries outstanding");
    report(model_q[0].tag, model_q[0].pl);
    expect_retire("full_buffer");
    if (!disp_ready)
      abort("full_buffer: disp_ready still low after a retirement");
    for (int i = 0; i < 7; i++)
      report(model_q[i].tag, model_q[i].pl);
    repeat (7) expect_retire("full_buffer");
  endtask

  task automatic test_alignment();
    dispatch("mal_load", commit_pkg::load, 32'h0000_3000, 5'd6, data_pl(32'h0000_8003));
    dispatch("mal_load", commit_pkg::alu, 32'h0000_3004, 5'd7, data_pl(next_rand()));
    report(model_q[1].tag, model_q[1].pl);  // Younger finishes first
    report(model_q[0].tag, model_q[0].pl);
    expect_retire("mal_load");
    check_quiet("mal_load", 6);
    dispatch("mal_store", commit_pkg::store, 32'h0000_3100, 5'd0, data_pl(32'h0000_9002));
    report(model_q[0].tag, model_q[0].pl);
    expect_retire("mal_store");
    dispatch("mal_insn", commit_pkg::jump, 32'h0000_3200, 5'd1,
             ctrl_pl(1'b1, 1'b1, 32'h0000_4002));
    report(model_q[0].tag, model_q[0].pl);
    expect_retire("mal_insn");
  endtask

  task automatic test_ecall();
    dispatch("ecall", commit_pkg::ecall, 32'h0000_4000, 5'd0, data_pl(32'd0));
    dispatch("ecall", commit_pkg::alu, 32'h0000_4004, 5'd3, data_pl(next_rand()));
    report(model_q[1].tag, model_q[1].pl);
    report(model_q[0].tag, model_q[0].pl);
    expect_retire("ecall");
    check_quiet("ecall", 4);
    dispatch("after_ecall", commit_pkg::alu, 32'h0000_5000, 5'd4, data_pl(next_rand()));
    dispatch("after_ecall", commit_pkg::mul, 32'h0000_5004, 5'd5, data_pl(next_rand()));
    report(model_q[1].tag, model_q[1].pl);
    report(model_q[0].tag, model_q[0].pl);
    repeat (2) expect_retire("after_ecall");
  endtask

  task automatic test_branch();
    logic [commit_pkg::tag_w-1:0] y_tag;
    commit_pkg::fu_payload_u      y_pl;
    dispatch("branch_hit", commit_pkg::branch, 32'h0000_6000, 5'd0,
             ctrl_pl(1'b1, 1'b1, 32'h0000_6100));
    report(model_q[0].tag, model_q[0].pl);
    expect_retire("branch_hit");
    // Wrong-path entry lands on slot 0, the head after the flush
    while (next_tag != 3'd7) begin
      dispatch("branch_fill", commit_pkg::alu, 32'h0000_6800 + 32'(next_tag) * 32'd4, 5'd2,
               data_pl(next_rand()));
      report(model_q[0].tag, model_q[0].pl);
      expect_retire("branch_fill");
    end
    dispatch("branch_miss", commit_pkg::branch, 32'h0000_6100, 5'd0,
             ctrl_pl(1'b0, 1'b1, 32'h0000_6200));
    dispatch("branch_miss", commit_pkg::alu, 32'h0000_6104, 5'd9, data_pl(next_rand()));
    y_tag = model_q[1].tag;
    y_pl  = model_q[1].pl;
    report(model_q[0].tag, model_q[0].pl);
    expect_retire("branch_miss");
    report(y_tag, y_pl);  // Wrong-path result after the flush
    check_quiet("branch_miss", 6);
    dispatch("jump", commit_pkg::jump, 32'h0000_7000, 5'd1,
             ctrl_pl(1'b1, 1'b1, 32'h0000_7400));
    report(model_q[0].tag, model_q[0].pl);
    expect_retire("jump");
  endtask

  initial begin
    nRST       = 1'b0;
    disp_valid = 1'b0;
    disp_kind  = commit_pkg::alu;
    disp_pc    = '0;
    disp_rd    = '0;
    fu_valid   = '0;
    fu_tag     = '0;
    fu_payload = '0;
    repeat (16) @(posedge CLK);
    #2;
    nRST = 1'b1;
    test_reset_state();
    test_in_order();
    test_full_buffer();
    test_alignment();
    test_ecall();
    test_branch();
    $display("=== PASS ===");
    $finish;
  end

endmodule

// File: logic/commit_ifs.sv
`timescale 1ns/100ps

// Internal links of the commit unit
// fu_issue_if carries a live result plus its metadata into a lane,
// wb_record_if carries the classified record into the completion buffer

interface fu_issue_if;
  logic                           valid;    // Result for a live tag
  logic [commit_pkg::tag_w-1:0]   tag;
  commit_pkg::rob_meta_t          meta;     // Kind, PC, rd stored at dispatch
  commit_pkg::fu_payload_u        payload;

  modport source (
    output valid, tag, meta, payload
  );

  modport sink (
    input valid, tag, meta, payload
  );
endinterface

interface wb_record_if;
  logic                  valid;  // One-cycle record strobe
  commit_pkg::wb_rec_t   rec;

  modport source (
    output valid, rec
  );

  modport sink (
    input valid, rec
  );
endinterface

// File: logic/commit_pkg.sv
// Shared sizes and types for the retirement end of the OoO core
// Kinds, exception causes, result payload views and per-tag records

package commit_pkg;

  localparam int rob_depth = 8;  // Completion-buffer slots
  localparam int tag_w     = 3;  // Tag names one slot
  localparam int num_lanes = 4;  // FU result ports and lanes

  typedef enum logic [2:0] {
    alu, mul, div, load, store, branch, jump, ecall
  } kind_t;

  typedef enum logic [2:0] {
    none, mal_insn, mal_load, mal_store, env_call
  } cause_t;

  // One result word, read by kind
  typedef union packed {
    struct packed {
      logic [1:0]  pad;        // Unused in data view
      logic [31:0] word;       // Reg value, or ld/st address
    } data;
    struct packed {
      logic        taken;      // Resolved direction
      logic        predicted;  // Direction from the predictor
      logic [31:0] target;     // Resolved target
    } ctrl;
  } fu_payload_u;

  typedef struct packed {
    logic [tag_w-1:0] tag;
    kind_t            kind;
    logic [4:0]       rd;
    logic [31:0]      pc;
    logic [31:0]      wdata;
    cause_t           cause;
    logic [31:0]      badaddr;
    logic             taken;
    logic             mispredict;
    logic [31:0]      target;
  } wb_rec_t;

  // Kept per tag at dispatch
  typedef struct packed {
    kind_t       kind;
    logic [31:0] pc;
    logic [4:0]  rd;
  } rob_meta_t;

endpackage

// File: logic/completion_buffer.sv
`timescale 1ns/100ps

// In-order completion buffer, indexed by tag
// Retires the head once done, as a register commit or an exception,
// and flushes all younger entries on exception or mispredict

module completion_buffer (
  input  logic                 CLK,
  input  logic                 nRST,
  wb_record_if.sink            wb [commit_pkg::num_lanes],
  output logic                 retire,
  output logic                 flush,
  output logic                 commit_valid,
  output logic                 commit_wen,
  output logic [4:0]           commit_rd,
  output logic [31:0]          commit_pc,
  output logic [31:0]          commit_wdata,
  output logic                 exc_valid,
  output commit_pkg::cause_t   exc_cause,
  output logic [31:0]          exc_epc,
  output logic [31:0]          exc_badaddr,
  output logic                 pred_update,
  output logic [31:0]          pred_pc,
  output logic [31:0]          pred_target,
  output logic                 pred_taken,
  output logic                 mispredict
);

  logic [commit_pkg::tag_w-1:0]     head;       // Oldest entry
  logic [commit_pkg::rob_depth-1:0] done;       // Record present per slot
  commit_pkg::wb_rec_t              recs [commit_pkg::rob_depth];
  logic [commit_pkg::num_lanes-1:0] lane_valid;
  commit_pkg::wb_rec_t              lane_rec [commit_pkg::num_lanes];
  commit_pkg::wb_rec_t              hd;         // Head record
  logic                             has_cause;
  logic                             is_ctrl;
  logic                             writes_rd;  // Kind produces a reg value

  // Gather the lane records into plain arrays
  for (genvar i = 0; i < commit_pkg::num_lanes; i++) begin : g_lane
    assign lane_valid[i] = wb[i].valid;
    assign lane_rec[i]   = wb[i].rec;
  end

  assign hd        = recs[head];
  assign has_cause = hd.cause != commit_pkg::none;
  assign is_ctrl   = (hd.kind == commit_pkg::branch) || (hd.kind == commit_pkg::jump);
  assign writes_rd = (hd.kind == commit_pkg::alu) || (hd.kind == commit_pkg::mul) ||
                     (hd.kind == commit_pkg::div) || (hd.kind == commit_pkg::load) ||
                     (hd.kind == commit_pkg::jump);

  assign retire       = done[head];                // At most one per cycle
  assign commit_valid = retire & ~has_cause;
  assign exc_valid    = retire & has_cause;
  assign commit_wen   = commit_valid & writes_rd & (hd.rd != 5'd0);  // x0 never written
  assign commit_rd    = hd.rd;
  assign commit_pc    = hd.pc;
  assign commit_wdata = hd.wdata;
  assign exc_cause    = hd.cause;
  assign exc_epc      = hd.pc;
  assign exc_badaddr  = hd.badaddr;

  // One predictor update per retiring branch or jump
  assign pred_update = commit_valid & is_ctrl;
  assign pred_pc     = hd.pc;
  assign pred_target = hd.target;
  assign pred_taken  = hd.taken;
  assign mispredict  = pred_update & hd.mispredict;
  assign flush       = exc_valid | mispredict;  // Younger entries are wrong path

  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      head <= '0;
      done <= '0;
    end else if (flush) begin
      head <= '0;  // Dispatch tail resets in the same edge
      done <= '0;
    end else begin
      if (retire) begin
        done[head] <= 1'b0;
        head       <= head + 1'b1;
      end
      for (int i = 0; i < commit_pkg::num_lanes; i++) begin
        if (lane_valid[i])
          done[lane_rec[i].tag] <= 1'b1;  // Tags never collide across lanes
      end
    end
  end

  // Record storage, indexed by tag
  always_ff @(posedge CLK) begin
    for (int i = 0; i < commit_pkg::num_lanes; i++) begin
      if (lane_valid[i])
        recs[lane_rec[i].tag] <= lane_rec[i];
    end
  end

endmodule

// File: logic/fu_writeback_lane.sv
`timescale 1ns/100ps

// One writeback lane: classifies a finished result and registers
// a record with cause, bad address and branch outcome

module fu_writeback_lane (
  input logic         CLK,
  input logic         nRST,
  fu_issue_if.sink    iss,
  wb_record_if.source wb
);

  commit_pkg::wb_rec_t rec_nxt;
  logic                is_ctrl;  // Branch or jump, ctrl view applies
  logic [31:0]         word;     // Data view
  logic [31:0]         target;   // Ctrl view

  assign is_ctrl = (iss.meta.kind == commit_pkg::branch) || (iss.meta.kind == commit_pkg::jump);
  assign word    = iss.payload.data.word;
  assign target  = iss.payload.ctrl.target;

  always_comb begin
    rec_nxt.tag        = iss.tag;
    rec_nxt.kind       = iss.meta.kind;
    rec_nxt.rd         = iss.meta.rd;
    rec_nxt.pc         = iss.meta.pc;
    rec_nxt.wdata      = (iss.meta.kind == commit_pkg::jump) ? iss.meta.pc + 32'd4 : word;
    rec_nxt.taken      = is_ctrl & iss.payload.ctrl.taken;
    rec_nxt.mispredict = is_ctrl & (iss.payload.ctrl.taken != iss.payload.ctrl.predicted);
    rec_nxt.target     = target;
    rec_nxt.cause      = commit_pkg::none;
    rec_nxt.badaddr    = '0;
    case (iss.meta.kind)
      commit_pkg::branch, commit_pkg::jump: begin
        rec_nxt.badaddr = target;  // Reported only for mal_insn
        if (target[1:0] != 2'b00)
          rec_nxt.cause = commit_pkg::mal_insn;
      end
      commit_pkg::load: begin
        rec_nxt.badaddr = word;
        if (word[1:0] != 2'b00)
          rec_nxt.cause = commit_pkg::mal_load;
      end
      commit_pkg::store: begin
        rec_nxt.badaddr = word;
        if (word[1:0] != 2'b00)
          rec_nxt.cause = commit_pkg::mal_store;
      end
      commit_pkg::ecall: rec_nxt.cause = commit_pkg::env_call;
      default: ;  // alu, mul, div never fault
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST)
      wb.valid <= 1'b0;
    else
      wb.valid <= iss.valid;  // One-cycle strobe per result
  end

  always_ff @(posedge CLK) begin
    if (iss.valid)
      wb.rec <= rec_nxt;
  end

endmodule

// File: logic/ooo_commit_unit.sv
`timescale 1ns/100ps

// Retirement end of the OoO core
// Dispatch tagging, four writeback lanes and the completion buffer

module ooo_commit_unit (
  input  logic                                                   CLK,
  input  logic                                                   nRST,
  input  logic                                                   disp_valid,
  input  commit_pkg::kind_t                                      disp_kind,
  input  logic [31:0]                                            disp_pc,
  input  logic [4:0]                                             disp_rd,
  output logic                                                   disp_ready,
  output logic [commit_pkg::tag_w-1:0]                           disp_tag,
  input  logic [commit_pkg::num_lanes-1:0]                       fu_valid,
  input  logic [commit_pkg::num_lanes-1:0][commit_pkg::tag_w-1:0] fu_tag,
  input  commit_pkg::fu_payload_u [commit_pkg::num_lanes-1:0]    fu_payload,
  output logic                                                   commit_valid,
  output logic                                                   commit_wen,
  output logic [4:0]                                             commit_rd,
  output logic [31:0]                                            commit_pc,
  output logic [31:0]                                            commit_wdata,
  output logic                                                   exc_valid,
  output commit_pkg::cause_t                                     exc_cause,
  output logic [31:0]                                            exc_epc,
  output logic [31:0]                                            exc_badaddr,
  output logic                                                   pred_update,
  output logic [31:0]                                            pred_pc,
  output logic [31:0]                                            pred_target,
  output logic                                                   pred_taken,
  output logic                                                   mispredict
);

  logic retire;  // Head slot freed
  logic flush;   // Drop all in-flight entries

  fu_issue_if  iss [commit_pkg::num_lanes] ();
  wb_record_if wb  [commit_pkg::num_lanes] ();

  rob_dispatch u_dispatch (
    .CLK        (CLK),
    .nRST       (nRST),
    .disp_valid (disp_valid),
    .disp_kind  (disp_kind),
    .disp_pc    (disp_pc),
    .disp_rd    (disp_rd),
    .disp_ready (disp_ready),
    .disp_tag   (disp_tag),
    .fu_valid   (fu_valid),
    .fu_tag     (fu_tag),
    .fu_payload (fu_payload),
    .retire     (retire),
    .flush      (flush),
    .iss        (iss)
  );

  for (genvar i = 0; i < commit_pkg::num_lanes; i++) begin : g_lane
    fu_writeback_lane u_lane (
      .CLK  (CLK),
      .nRST (nRST),
      .iss  (iss[i]),
      .wb   (wb[i])
    );
  end

  completion_buffer u_cbuf (
    .CLK          (CLK),
    .nRST         (nRST),
    .wb           (wb),
    .retire       (retire),
    .flush        (flush),
    .commit_valid (commit_valid),
    .commit_wen   (commit_wen),
    .commit_rd    (commit_rd),
    .commit_pc    (commit_pc),
    .commit_wdata (commit_wdata),
    .exc_valid    (exc_valid),
    .exc_cause    (exc_cause),
    .exc_epc      (exc_epc),
    .exc_badaddr  (exc_badaddr),
    .pred_update  (pred_update),
    .pred_pc      (pred_pc),
    .pred_target  (pred_target),
    .pred_taken   (pred_taken),
    .mispredict   (mispredict)
  );

endmodule

// File: logic/rob_dispatch.sv
`timescale 1ns/100ps

// In-order tag allocator for the completion buffer
// Stores kind, PC and rd per tag and tracks which tags are live
// Routes each live FU result, with its metadata, to its lane

module rob_dispatch (
  input  logic                                                   CLK,
  input  logic                                                   nRST,
  input  logic                                                   disp_valid,
  input  commit_pkg::kind_t                                      disp_kind,
  input  logic [31:0]                                            disp_pc,
  input  logic [4:0]                                             disp_rd,
  output logic                                                   disp_ready,
  output logic [commit_pkg::tag_w-1:0]                           disp_tag,
  input  logic [commit_pkg::num_lanes-1:0]                       fu_valid,
  input  logic [commit_pkg::num_lanes-1:0][commit_pkg::tag_w-1:0] fu_tag,
  input  commit_pkg::fu_payload_u [commit_pkg::num_lanes-1:0]    fu_payload,
  input  logic                                                   retire,
  input  logic                                                   flush,
  fu_issue_if.source                                             iss [commit_pkg::num_lanes]
);

  logic [commit_pkg::tag_w-1:0]     tail;       // Next tag to hand out
  logic [commit_pkg::tag_w-1:0]     head;       // Oldest occupied slot
  logic [commit_pkg::tag_w:0]       count;      // 0..rob_depth
  logic [commit_pkg::tag_w:0]       count_nxt;
  logic [commit_pkg::rob_depth-1:0] live;       // Dispatched, not yet freed
  commit_pkg::rob_meta_t            meta_mem [commit_pkg::rob_depth];
  logic                             accept;

  assign accept   = disp_valid & disp_ready;
  assign disp_tag = tail;                                // Same-cycle tag
  assign head     = tail - count[commit_pkg::tag_w-1:0]; // Wraps to tail when full

  always_comb begin
    if (flush) begin
      count_nxt = '0;  // Everything in flight is discarded
    end else begin
      count_nxt = count + (commit_pkg::tag_w+1)'(accept) - (commit_pkg::tag_w+1)'(retire);
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (~nRST) begin
      tail       <= '0;
      count      <= '0;
      live       <= '0;
      disp_ready <= 1'b0;  // Comes up one cycle after reset
    end else begin
      count      <= count_nxt;
      disp_ready <= count_nxt != (commit_pkg::tag_w+1)'(commit_pkg::rob_depth);
      if (flush) begin
        tail <= '0;  // Realign with the buffer head
        live <= '0;
      end else begin
        if (retire)
          live[head] <= 1'b0;  // Head slot freed
        if (accept) begin
          live[tail] <= 1'b1;
          tail       <= tail + 1'b1;
        end
      end
    end
  end

  // Metadata table, written at the tail
  always_ff @(posedge CLK) begin
    if (accept) begin
      meta_mem[tail].kind <= disp_kind;
      meta_mem[tail].pc   <= disp_pc;
      meta_mem[tail].rd   <= disp_rd;
    end
  end

  for (genvar i = 0; i < commit_pkg::num_lanes; i++) begin : g_issue
    // Stale tags and results racing a flush are dropped here
    assign iss[i].valid   = fu_valid[i] & live[fu_tag[i]] & ~flush;
    assign iss[i].tag     = fu_tag[i];
    assign iss[i].meta    = meta_mem[fu_tag[i]];
    assign iss[i].payload = fu_payload[i];
  end

endmodule

// File: ooo_commit_unit.f
logic/commit_pkg.sv
logic/commit_ifs.sv
logic/rob_dispatch.sv
logic/fu_writeback_lane.sv
logic/completion_buffer.sv
logic/ooo_commit_unit.sv
bench/completion_buffer_checker.sv
bench/ooo_commit_unit_tb.sv
